// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_event_req_gen
FILELIST = all.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
+incdir+src
src/req_gen_pkg.sv
src/sync_fifo.sv
src/chunk_addr_fsm.sv
src/dm_cmd_issue.sv
src/dm_status_track.sv
src/event_req_gen.sv
test/tb_event_req_gen.sv

// ==== src/chunk_addr_fsm.sv ====
`timescale 1ns/1ps

module chunk_addr_fsm import req_gen_pkg::*; #(
    parameter logic [6:0] BASE_ADDR_4KB = 7'd4
) (
    input  logic                       memclk,
    input  logic                       memresetn,
    input  payload_ctl_t               payload_ctl_i,
    input  logic [`DONE_ADDR_BITS-1:0] done_addr_i,
    input  logic                       done_valid_i,
    input  logic                       store_space_i,
    output cmd_entry_t                 entry_o,
    output logic                       entry_wr_o,
    output logic                       done_ready_o,
    output logic                       payload_has_space_o
);
    localparam logic [1:0] IDLE      = 2'd0;
    localparam logic [1:0] LOAD      = 2'd1;
    localparam logic [1:0] WAIT_LAST = 2'd2;
    localparam logic [1:0] INCREMENT = 2'd3;

    // base in KB, 4x the 4 KB parameter
    localparam logic [8:0] BASE_KB = {BASE_ADDR_4KB, 2'b00};

    logic [1:0] state_q;
    logic [1:0] chunk_q;
    logic [8:0] chunk_addr_q;
    logic [8:0] chunk_lookup [4];
    logic [8:0] addend_a;
    logic [8:0] addend_b;
    logic [2:0] surf;
    logic       last_beat;
    logic       last_surf;
    logic       final_cmd;

    assign surf      = payload_ctl_i.ident[4:2];
    assign last_beat = payload_ctl_i.valid && payload_ctl_i.last;
    assign last_surf = (surf == 3'(`LAST_SURF));
    assign final_cmd = last_surf && (payload_ctl_i.ident[1:0] == 2'(`LAST_CHUNK));

    // starting address of each chunk number for surf 0
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            chunk_lookup[i] = BASE_KB + 9'(i * `CHUNK_SIZE_KB);
        end
    end

    ////////////////////////////////////////////////////////////////////
    // single adder: lookup in LOAD, surf step in INCREMENT
    ////////////////////////////////////////////////////////////////////
    assign addend_a = (state_q == LOAD) ? chunk_lookup[chunk_q] : chunk_addr_q;
    assign addend_b = (state_q == INCREMENT) ? 9'(`SURF_STEP_KB) : 9'd0;

    always_ff @(posedge memclk) begin
        if (state_q == LOAD || state_q == INCREMENT) begin
            chunk_addr_q <= addend_a + addend_b;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state_q <= IDLE;
            chunk_q <= 2'd0;
        end else begin
            case (state_q)
                IDLE: begin
                    // first beat of an event, remember its chunk number
                    if (payload_ctl_i.valid && done_valid_i) begin
                        chunk_q <= payload_ctl_i.ident[1:0];
                        state_q <= LOAD;
                    end
                end
                LOAD: state_q <= WAIT_LAST;
                WAIT_LAST: begin
                    if (last_beat) begin
                        if (final_cmd) begin
                            state_q <= IDLE;
                        end else if (last_surf) begin
                            // wrap back to surf 0 of the next chunk
                            chunk_q <= chunk_q + 2'd1;
                            state_q <= LOAD;
                        end else begin
                            state_q <= INCREMENT;
                        end
                    end
                end
                default: state_q <= WAIT_LAST;
            endcase
        end
    end

    // command entry goes out on the last beat of each surf chunk
    assign entry_wr_o          = (state_q == WAIT_LAST) && last_beat;
    assign entry_o.final_cmd   = final_cmd;
    assign entry_o.done_addr   = done_addr_i;
    assign entry_o.chunk_kb    = chunk_addr_q;
    // done address is consumed with the final command
    assign done_ready_o        = entry_wr_o && final_cmd;
    assign payload_has_space_o = (state_q == IDLE) && done_valid_i && store_space_i;

endmodule

// ==== src/dm_cmd_issue.sv ====
`timescale 1ns/1ps

module dm_cmd_issue import req_gen_pkg::*; (
    input  logic       memclk,
    input  logic       memresetn,
    input  cmd_entry_t entry_i,
    input  logic       entry_wr_i,
    input  logic       dm_cmd_ready_i,
    output dm_cmd_t    dm_cmd_o,
    output logic       dm_cmd_valid_o,
    output logic       overflow_o
);
    localparam int ENTRY_W = $bits(cmd_entry_t);

    logic [ENTRY_W-1:0] head_bits;
    cmd_entry_t         head;
    logic               cmd_rd;

    // pop on every accepted command
    assign cmd_rd = dm_cmd_valid_o && dm_cmd_ready_i;

    sync_fifo #(
        .WIDTH (ENTRY_W),
        .DEPTH (`CMD_FIFO_DEPTH)
    ) cmd_fifo_inst (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .din_i       (entry_i),
        .wr_i        (entry_wr_i),
        .rd_i        (cmd_rd),
        .dout_o      (head_bits),
        .valid_o     (dm_cmd_valid_o),
        .overflow_o  (overflow_o),
        .underflow_o ()
    );

    assign head = cmd_entry_t'(head_bits);

    ////////////////////////////////////////////////////////////////////
    // expand queue head into the 72-bit command
    ////////////////////////////////////////////////////////////////////
    assign dm_cmd_o.rsvd  = 4'h0;
    // tag bit 0 marks the last chunk of the event
    assign dm_cmd_o.tag   = {3'b000, head.final_cmd};
    // chunks are KB aligned so the low 10 bits are zero
    assign dm_cmd_o.addr  = {head.done_addr, head.chunk_kb, 10'h000};
    assign dm_cmd_o.drr   = `CMD_DRR;
    assign dm_cmd_o.eof   = `CMD_EOF;
    assign dm_cmd_o.dsa   = `CMD_DSA;
    assign dm_cmd_o.dtype = `CMD_TYPE;
    assign dm_cmd_o.btt   = 23'(`CHUNK_BTT);

endmodule

// ==== src/dm_status_track.sv ====
`timescale 1ns/1ps

module dm_status_track import req_gen_pkg::*; (
    input  logic                       memclk,
    input  logic                       memresetn,
    input  logic [`DONE_ADDR_BITS-1:0] done_addr_i,
    input  logic                       done_wr_i,
    input  dm_status_t                 dm_status_i,
    input  logic                       dm_status_valid_i,
    input  logic                       cmpl_ready_i,
    output cmpl_t                      cmpl_o,
    output logic                       cmpl_valid_o,
    output logic                       done_overflow_o,
    output logic                       done_underflow_o,
    output logic                       cmpl_overflow_o
);
    logic [3:0]                   cur_err;
    logic                         err_any;
    logic                         last_status;
    logic [3:0]                   sticky_q;
    logic [`ERR_HIST_BITS-1:0]    hist_q;
    logic [`DONE_ADDR_BITS-1:0]   done_head;
    cmpl_t                        cmpl_in;
    logic [`CMPL_FIFO_BITS-1:0]   cmpl_head;
    logic                         cmpl_rd;

    ////////////////////////////////////////////////////////////////////
    // status decode
    ////////////////////////////////////////////////////////////////////
    // status is always accepted
    assign cur_err     = {!dm_status_i.ok, dm_status_i.err};
    assign err_any     = |cur_err;
    // last bit follows the command tag, so it marks the event's final chunk
    assign last_status = dm_status_valid_i && dm_status_i.last;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            sticky_q <= 4'h0;
            hist_q   <= '0;
        end else if (dm_status_valid_i) begin
            // sticky errors gather over one event
            if (dm_status_i.last) begin
                sticky_q <= 4'h0;
            end else begin
                sticky_q <= sticky_q | cur_err;
            end
            // one bit per chunk, oldest falls out the bottom
            hist_q <= {err_any, hist_q[`ERR_HIST_BITS-1:1]};
        end
    end

    // done addresses wait here until the event's last status
    sync_fifo #(
        .WIDTH (`DONE_ADDR_BITS),
        .DEPTH (`DONE_FIFO_DEPTH)
    ) done_fifo_inst (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .din_i       (done_addr_i),
        .wr_i        (done_wr_i),
        .rd_i        (last_status),
        .dout_o      (done_head),
        .valid_o     (),
        .overflow_o  (done_overflow_o),
        .underflow_o (done_underflow_o)
    );

    ////////////////////////////////////////////////////////////////////
    // completion word and queue
    ////////////////////////////////////////////////////////////////////
    // the final chunk rides in logic, history holds the 27 before it
    assign cmpl_in.zero       = '0;
    assign cmpl_in.done_addr  = done_head;
    assign cmpl_in.final_err  = err_any;
    assign cmpl_in.err_hist   = hist_q;
    assign cmpl_in.sticky_err = sticky_q | cur_err;

    assign cmpl_rd = cmpl_valid_o && cmpl_ready_i;

    sync_fifo #(
        .WIDTH (`CMPL_FIFO_BITS),
        .DEPTH (`CMPL_FIFO_DEPTH)
    ) cmpl_fifo_inst (
        .memclk      (memclk),
        .memresetn   (memresetn),
        .din_i       (cmpl_in[`CMPL_FIFO_BITS-1:0]),
        .wr_i        (last_status),
        .rd_i        (cmpl_rd),
        .dout_o      (cmpl_head),
        .valid_o     (cmpl_valid_o),
        .overflow_o  (cmpl_overflow_o),
        .underflow_o ()
    );

    // zero padding restored on the way out
    assign cmpl_o = cmpl_t'({{(64 - `CMPL_FIFO_BITS){1'b0}}, cmpl_head});

endmodule

// ==== src/event_req_gen.sv ====
`timescale 1ns/1ps

module event_req_gen import req_gen_pkg::*; #(
    parameter logic [6:0] BASE_ADDR_4KB = 7'd4
) (
    input  logic                       memclk,
    input  logic                       memresetn,
    // payload control strobes, no handshake
    input  payload_ctl_t               payload_ctl_i,
    input  logic                       store_space_i,
    output logic                       payload_has_space_o,
    // done address stream
    input  logic [`DONE_ADDR_BITS-1:0] done_addr_i,
    input  logic                       done_valid_i,
    output logic                       done_ready_o,
    // datamover command stream
    output dm_cmd_t                    dm_cmd_o,
    output logic                       dm_cmd_valid_o,
    input  logic                       dm_cmd_ready_i,
    // datamover status, always accepted
    input  dm_status_t                 dm_status_i,
    input  logic                       dm_status_valid_i,
    // completion stream
    output cmpl_t                      cmpl_o,
    output logic                       cmpl_valid_o,
    input  logic                       cmpl_ready_i,
    output fifo_err_t                  fifo_err_o
);
    cmd_entry_t entry;
    logic       entry_wr;
    fifo_err_t  err_pulse;

    ////////////////////////////////////////////////////////////////////
    // command side
    ////////////////////////////////////////////////////////////////////
    chunk_addr_fsm #(
        .BASE_ADDR_4KB (BASE_ADDR_4KB)
    ) chunk_addr_fsm_inst (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .payload_ctl_i       (payload_ctl_i),
        .done_addr_i         (done_addr_i),
        .done_valid_i        (done_valid_i),
        .store_space_i       (store_space_i),
        .entry_o             (entry),
        .entry_wr_o          (entry_wr),
        .done_ready_o        (done_ready_o),
        .payload_has_space_o (payload_has_space_o)
    );

    dm_cmd_issue dm_cmd_issue_inst (
        .memclk         (memclk),
        .memresetn      (memresetn),
        .entry_i        (entry),
        .entry_wr_i     (entry_wr),
        .dm_cmd_ready_i (dm_cmd_ready_i),
        .dm_cmd_o       (dm_cmd_o),
        .dm_cmd_valid_o (dm_cmd_valid_o),
        .overflow_o     (err_pulse.cmd_overflow)
    );

    ////////////////////////////////////////////////////////////////////
    // status side
    ////////////////////////////////////////////////////////////////////
    // done address is queued together with the final command
    dm_status_track dm_status_track_inst (
        .memclk            (memclk),
        .memresetn         (memresetn),
        .done_addr_i       (done_addr_i),
        .done_wr_i         (entry_wr && entry.final_cmd),
        .dm_status_i       (dm_status_i),
        .dm_status_valid_i (dm_status_valid_i),
        .cmpl_ready_i      (cmpl_ready_i),
        .cmpl_o            (cmpl_o),
        .cmpl_valid_o      (cmpl_valid_o),
        .done_overflow_o   (err_pulse.done_overflow),
        .done_underflow_o  (err_pulse.done_underflow),
        .cmpl_overflow_o   (err_pulse.cmpl_overflow)
    );

    // sticky until reset
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            fifo_err_o <= '0;
        end else begin
            fifo_err_o <= fifo_err_o | err_pulse;
        end
    end

endmodule

// ==== src/req_gen_consts.svh ====
`ifndef REQ_GEN_CONSTS_SVH
`define REQ_GEN_CONSTS_SVH

// chunk and event geometry
`define CHUNK_SIZE_KB 4
// four chunks per surf
`define SURF_STEP_KB 16
`define NUM_SURFS 7
`define LAST_SURF (`NUM_SURFS - 1)
`define LAST_CHUNK 3

// field widths
`define DONE_ADDR_BITS 13
`define CHUNK_KB_BITS 9
`define ERR_HIST_BITS 27
// done address + final error + history + sticky nibble
`define CMPL_FIFO_BITS 45

// queue depths
`define CMD_FIFO_DEPTH 32
`define DONE_FIFO_DEPTH 16
`define CMPL_FIFO_DEPTH 16

// fixed datamover command fields
`define CHUNK_BTT 4096
// no realignment
`define CMD_DRR 1'b0
// tlast expected at end of each chunk
`define CMD_EOF 1'b1
`define CMD_DSA 6'b000000
// incrementing address burst
`define CMD_TYPE 1'b1

`endif

// ==== src/req_gen_pkg.sv ====
package req_gen_pkg;
`include "req_gen_consts.svh"

    // payload control strobes, ident is {surf[2:0], chunk[1:0]}
    typedef struct packed {
        logic       valid;
        logic       last;
        logic [4:0] ident;
    } payload_ctl_t;

    // one queued command, address bits [31:10] plus final marker
    typedef struct packed {
        logic                         final_cmd;
        logic [`DONE_ADDR_BITS-1:0]   done_addr;
        logic [`CHUNK_KB_BITS-1:0]    chunk_kb;
    } cmd_entry_t;

    // 72-bit datamover s2mm command
    typedef struct packed {
        logic [3:0]  rsvd;
        logic [3:0]  tag;
        logic [31:0] addr;
        logic        drr;
        logic        eof;
        logic [5:0]  dsa;
        logic        dtype;
        logic [22:0] btt;
    } dm_cmd_t;

    // 8-bit datamover status, ok in bit 7
    typedef struct packed {
        logic       ok;
        logic [2:0] err;
        logic [2:0] unused;
        logic       last;
    } dm_status_t;

    // 64-bit completion word
    typedef struct packed {
        logic [63-`CMPL_FIFO_BITS:0]  zero;
        logic [`DONE_ADDR_BITS-1:0]   done_addr;
        logic                         final_err;
        logic [`ERR_HIST_BITS-1:0]    err_hist;
        logic [3:0]                   sticky_err;
    } cmpl_t;

    // sticky fifo errors, bit 0 is command overflow
    typedef struct packed {
        logic done_underflow;
        logic cmpl_overflow;
        logic done_overflow;
        logic cmd_overflow;
    } fifo_err_t;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             memclk,
    input  logic             memresetn,
    input  logic [WIDTH-1:0] din_i,
    input  logic             wr_i,
    input  logic             rd_i,
    output logic [WIDTH-1:0] dout_o,
    output logic             valid_o,
    output logic             overflow_o,
    output logic             underflow_o
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;
    logic             full;
    logic             wr_ok;
    logic             rd_ok;

    assign full  = (count_q == CW'(DEPTH));
    // write when full is dropped, read when empty is ignored
    assign wr_ok = wr_i && !full;
    assign rd_ok = rd_i && valid_o;

    // first word falls through, head is visible as soon as count is nonzero
    assign valid_o = (count_q != '0);
    assign dout_o  = mem[rd_ptr_q];

    // storage array
    always_ff @(posedge memclk) begin
        if (wr_ok) begin
            mem[wr_ptr_q] <= din_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
            // error flags are single-cycle pulses
            overflow_o  <= wr_i && full;
            underflow_o <= rd_i && !valid_o;
        end
    end

endmodule

// ==== test/tb_event_req_gen.sv ====
`timescale 1ns/1ps
`include "req_gen_consts.svh"

module tb_event_req_gen
    import req_gen_pkg::*;
();
    // base of 21 x 4 KB keeps every chunk address below 512 KB
    localparam int BASE_4KB = 21;

    logic         memclk;
    logic         memresetn       = 1'b0;
    payload_ctl_t payload_ctl     = '0;
    logic         store_space     = 1'b0;
    logic         has_space;
    logic [12:0]  done_addr       = '0;
    logic         done_valid      = 1'b0;
    logic         done_ready;
    dm_cmd_t      dm_cmd;
    logic         dm_cmd_valid;
    logic         dm_cmd_ready    = 1'b0;
    dm_status_t   dm_status       = '0;
    logic         dm_status_valid = 1'b0;
    cmpl_t        cmpl;
    logic         cmpl_valid;
    logic         cmpl_ready      = 1'b0;
    fifo_err_t    fifo_err;

    integer       seed = 10;

    // reference model state
    dm_cmd_t      exp_cmd[$];
    logic         pend_tag[$];
    logic [12:0]  exp_done[$];
    cmpl_t        exp_cmpl[$];
    logic [3:0]   sticky_m = '0;
    logic [26:0]  hist_m = '0;
    int           done_pulses = 0;
    bit           stall_en = 1'b0;
    bit           hold_cmpl = 1'b0;
    bit           cmpl_check_en = 1'b1;

    event_req_gen #(
        .BASE_ADDR_4KB (7'(BASE_4KB))
    ) event_req_gen_inst (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .payload_ctl_i       (payload_ctl),
        .store_space_i       (store_space),
        .payload_has_space_o (has_space),
        .done_addr_i         (done_addr),
        .done_valid_i        (done_valid),
        .done_ready_o        (done_ready),
        .dm_cmd_o            (dm_cmd),
        .dm_cmd_valid_o      (dm_cmd_valid),
        .dm_cmd_ready_i      (dm_cmd_ready),
        .dm_status_i         (dm_status),
        .dm_status_valid_i   (dm_status_valid),
        .cmpl_o              (cmpl),
        .cmpl_valid_o        (cmpl_valid),
        .cmpl_ready_i        (cmpl_ready),
        .fifo_err_o          (fifo_err)
    );

    // 4 ns clock
    initial begin
        memclk = 1'b0;
        forever #2 memclk = ~memclk;
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic fail_run();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic compare(input string name, input logic [71:0] got, input logic [71:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            fail_run();
        end
    endtask

    // expected command for one surf chunk
    function automatic dm_cmd_t expected_cmd(input logic [12:0] done, input int surf,
                                             input int chunk);
        dm_cmd_t    c;
        logic [8:0] kb;
        kb      = 9'(BASE_4KB * 4 + chunk * `CHUNK_SIZE_KB + surf * `SURF_STEP_KB);
        c       = '0;
        c.tag   = (surf == `LAST_SURF && chunk == `LAST_CHUNK) ? 4'h1 : 4'h0;
        c.addr  = {done, kb, 10'h000};
        c.drr   = 1'b0;
        c.eof   = 1'b1;
        c.dsa   = 6'h00;
        c.dtype = 1'b1;
        c.btt   = 23'(`CHUNK_BTT);
        return c;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // datamover responder and sinks
    //////////////////////////////////////////////////////////////////////
    always @(posedge memclk) begin : cmd_sink
        logic [31:0] r;
        r = next_rand();
        if (!memresetn) begin
            dm_cmd_ready <= 1'b0;
        end else begin
            dm_cmd_ready <= stall_en ? r[0] : 1'b1;
        end
    end

    always @(posedge memclk) begin : cmpl_sink
        logic [31:0] r;
        r = next_rand();
        if (!memresetn || hold_cmpl) begin
            cmpl_ready <= 1'b0;
        end else begin
            cmpl_ready <= stall_en ? r[0] : 1'b1;
        end
    end

    // one status per accepted command with the last bit taken from the tag
    always @(posedge memclk) begin : status_responder
        logic [31:0] r;
        dm_status_t  st;
        logic [3:0]  cur;
        cmpl_t       c;
        r = next_rand();
        if (!memresetn) begin
            dm_status_valid <= 1'b0;
        end else if (pend_tag.size() > 0 && r[1:0] != 2'b00) begin
            st.ok     = (r[4:2] != 3'b000);
            st.err    = (r[7:5] == 3'b000) ? r[10:8] : 3'b000;
            st.unused = 3'b000;
            st.last   = pend_tag.pop_front();
            dm_status       <= st;
            dm_status_valid <= 1'b1;
            // model of the error tracking
            cur = {~st.ok, st.err};
            if (st.last) begin
                if (exp_done.size() > 0) begin
                    c            = '0;
                    c.done_addr  = exp_done.pop_front();
                    c.final_err  = |cur;
                    c.err_hist   = hist_m;
                    c.sticky_err = sticky_m | cur;
                    if (cmpl_check_en) begin
                        exp_cmpl.push_back(c);
                    end
                end
                sticky_m = 4'h0;
            end else begin
                sticky_m = sticky_m | cur;
            end
            hist_m = {|cur, hist_m[26:1]};
        end else begin
            dm_status_valid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // monitors sample on the falling edge
    //////////////////////////////////////////////////////////////////////
    always @(negedge memclk) begin : cmd_monitor
        dm_cmd_t exp_c;
        if (memresetn && dm_cmd_valid && dm_cmd_ready) begin
            if (exp_cmd.size() == 0) begin
                $display("a command was issued while none was expected");
                fail_run();
            end
            exp_c = exp_cmd.pop_front();
            compare("dm_cmd_o", 72'(dm_cmd), 72'(exp_c));
            pend_tag.push_back(exp_c.tag[0]);
        end
    end

    always @(negedge memclk) begin : cmpl_monitor
        cmpl_t exp_c;
        if (memresetn && cmpl_valid && cmpl_ready) begin
            if (exp_cmpl.size() == 0) begin
                $display("a completion came out while none was expected");
                fail_run();
            end
            exp_c = exp_cmpl.pop_front();
            compare("cmpl_o", 72'(cmpl), 72'(exp_c));
        end
    end

    always @(negedge memclk) begin
        if (memresetn && done_ready) begin
            done_pulses++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////
    task automatic apply_reset();
        @(posedge memclk);
        memresetn   <= 1'b0;
        payload_ctl <= '0;
        done_valid  <= 1'b1;
        store_space <= 1'b1;
        repeat (16) @(posedge memclk);
        memresetn <= 1'b1;
        @(negedge memclk);
        compare("dm_cmd_valid_o", 72'(dm_cmd_valid), 72'(1'b0));
        compare("cmpl_valid_o", 72'(cmpl_valid), 72'(1'b0));
        // fsm in idle shows space once done valid and store space are high
        compare("payload_has_space_o", 72'(has_space), 72'(1'b1));
        compare("fifo_err_o", 72'(fifo_err), 72'(4'h0));
    endtask

    // one event of 28 surf chunks with the chunk number in the outer loop
    task automatic run_event(input logic [12:0] done);
        logic [31:0] r;
        int          nbeats;
        int          tries;
        int          pulses_before;
        bit          first;
        @(posedge memclk);
        done_addr   <= done;
        done_valid  <= 1'b1;
        store_space <= 1'b1;
        tries = 0;
        @(negedge memclk);
        while (!has_space) begin
            tries++;
            if (tries > 100) begin
                $display("payload_has_space_o never rose for a new event");
                fail_run();
            end
            @(negedge memclk);
        end
        exp_done.push_back(done);
        pulses_before = done_pulses;
        first = 1'b1;
        for (int chunk = 0; chunk < 4; chunk++) begin
            for (int surf = 0; surf < `NUM_SURFS; surf++) begin
                r = next_rand();
                nbeats = 3 + int'(r[1:0]);
                // occasional idle gap between chunks
                if (!first && r[3:2] == 2'b00) begin
                    @(posedge memclk);
                    payload_ctl <= '0;
                    @(negedge memclk);
                    compare("payload_has_space_o", 72'(has_space), 72'(1'b0));
                end
                for (int b = 0; b < nbeats; b++) begin
                    @(posedge memclk);
                    payload_ctl <= {1'b1, b == nbeats - 1, 3'(surf), 2'(chunk)};
                    if (b == nbeats - 1) begin
                        exp_cmd.push_back(expected_cmd(done, surf, chunk));
                    end
                    @(negedge memclk);
                    if (!first) begin
                        compare("payload_has_space_o", 72'(has_space), 72'(1'b0));
                    end
                    first = 1'b0;
                end
            end
        end
        // back in idle the space flag follows done valid and store space
        @(posedge memclk);
        payload_ctl <= '0;
        r = next_rand();
        done_valid  <= r[0];
        store_space <= r[1];
        @(negedge memclk);
        compare("payload_has_space_o", 72'(has_space), 72'(r[0] & r[1]));
        compare("done_ready_o pulses", 72'(done_pulses), 72'(pulses_before + 1));
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_cmd.size() != 0 || pend_tag.size() != 0 || exp_done.size() != 0 ||
               exp_cmpl.size() != 0) begin
            cycles++;
            if (cycles > 4000) begin
                $display("commands or completions were still outstanding after the timeout");
                fail_run();
            end
            @(negedge memclk);
        end
    endtask

    task automatic wait_err_bit(input int idx);
        int cycles;
        cycles = 0;
        while (!fifo_err[idx]) begin
            cycles++;
            if (cycles > 200) begin
                $display("fifo error bit %0d never got set", idx);
                fail_run();
            end
            @(negedge memclk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////
    initial begin : main
        logic [31:0] r;
        apply_reset();

        // free-flowing streams
        repeat (4) begin
            r = next_rand();
            run_event(r[12:0]);
        end
        wait_drained();

        // random back-pressure on commands and completions
        stall_en = 1'b1;
        repeat (10) begin
            r = next_rand();
            run_event(r[12:0]);
        end
        wait_drained();
        compare("fifo_err_o", 72'(fifo_err), 72'(4'h0));

        // the 17th blocked completion overflows
        cmpl_check_en = 1'b0;
        hold_cmpl = 1'b1;
        repeat (17) begin
            r = next_rand();
            run_event(r[12:0]);
        end
        wait_drained();
        wait_err_bit(2);
        compare("fifo_err_o", 72'(fifo_err), 72'(4'h4));

        // last status with no event pending
        pend_tag.push_back(1'b1);
        wait_err_bit(3);
        compare("fifo_err_o", 72'(fifo_err), 72'(4'hc));
        repeat (20) @(negedge memclk);
        compare("fifo_err_o", 72'(fifo_err), 72'(4'hc));

        // reset clears the sticky bits
        hold_cmpl = 1'b0;
        cmpl_check_en = 1'b1;
        pend_tag.delete();
        exp_cmd.delete();
        exp_done.delete();
        exp_cmpl.delete();
        sticky_m = 4'h0;
        hist_m = '0;
        apply_reset();
        repeat (3) begin
            r = next_rand();
            run_event(r[12:0]);
        end
        wait_drained();
        compare("fifo_err_o", 72'(fifo_err), 72'(4'h0));

        $display(">>> PASS");
        $finish;
    end

endmodule
